// File: rtl/bridge_params.svh
//--------------------------------------------------------------------------
// AHB to APB bridge parameters
// Bus widths, slave count and the APB address map
//--------------------------------------------------------------------------

`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH

// Bus widths
`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32

// Number of APB slaves behind the bridge
`define BRIDGE_NUM_SLAVES 4

//--------------------------------------------------------------------------
// Address map, 4 KB window per slave, inclusive bounds
//--------------------------------------------------------------------------
`define BRIDGE_SLAVE0_START 32'h0000_0000
`define BRIDGE_SLAVE0_END   32'h0000_0FFF
`define BRIDGE_SLAVE1_START 32'h0000_1000
`define BRIDGE_SLAVE1_END   32'h0000_1FFF
`define BRIDGE_SLAVE2_START 32'h0000_2000
`define BRIDGE_SLAVE2_END   32'h0000_2FFF
`define BRIDGE_SLAVE3_START 32'h0000_3000
`define BRIDGE_SLAVE3_END   32'h0000_3FFF
// Anything from 0x4000 upwards is unmapped

`endif

// File: rtl/ahb_pkg.sv
//--------------------------------------------------------------------------
// AHB side types for the bridge: address, data and transfer type
//--------------------------------------------------------------------------

`include "bridge_params.svh"

package ahb_pkg;

  // One address word and one data word
  typedef logic [`BRIDGE_ADDR_W-1:0] haddr_t;
  typedef logic [`BRIDGE_DATA_W-1:0] hdata_t;

  // htrans encoding
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_t;

endpackage

// File: rtl/apb_pkg.sv
//--------------------------------------------------------------------------
// APB side types for the bridge: FSM state, slave vectors, read data
//--------------------------------------------------------------------------

`include "bridge_params.svh"

package apb_pkg;

  // APB master states, one-hot
  typedef enum logic [2:0] {
    APB_IDLE   = 3'b001,
    APB_SETUP  = 3'b010,
    APB_ACCESS = 3'b100
  } apb_state_t;

  // One bit per slave, used for psel, pready and the decode result
  typedef logic [`BRIDGE_NUM_SLAVES-1:0] slave_vec_t;

  // Read data of all slaves, element i belongs to slave i
  typedef logic [`BRIDGE_NUM_SLAVES-1:0][`BRIDGE_DATA_W-1:0] prdata_arr_t;

endpackage

// File: rtl/ahb_slave_if.sv
//--------------------------------------------------------------------------
// AHB slave port of the bridge
// Accepts NONSEQ/SEQ transfers and stalls hready until the APB side is done
//--------------------------------------------------------------------------

`timescale 1ns/100ps

module ahb_slave_if (
  input  logic            hclk1,
  input  logic            hreset_n1,
  input  logic            hsel,
  input  ahb_pkg::haddr_t haddr,
  input  ahb_pkg::htrans_t htrans,
  input  logic            hwrite,
  output logic            hready,
  output ahb_pkg::hdata_t hrdata,
  output logic            xfer_req,
  output ahb_pkg::haddr_t req_addr,
  output logic            req_write,
  input  logic            xfer_done,
  input  ahb_pkg::hdata_t rdata
);

  import ahb_pkg::*;

  logic valid_trans;
  logic accept;
  logic addr_phase;
  logic data_phase;

  // Only NONSEQ and SEQ start an access, IDLE and BUSY are ignored
  assign valid_trans = hsel && ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));

  // Address phase completes when the slave is ready
  assign accept = addr_phase && valid_trans;

  //------------------------------------------------------------------------
  // Phase tracking
  //------------------------------------------------------------------------
  always_ff @(posedge hclk1 or negedge hreset_n1) begin
    if (!hreset_n1) begin
      addr_phase <= 1'b1;
      data_phase <= 1'b0;
      hrdata     <= '0;
    end else begin
      if (accept) begin
        // Enter data phase, hold the master off
        addr_phase <= 1'b0;
        data_phase <= 1'b1;
      end else if (data_phase && xfer_done) begin
        addr_phase <= 1'b1;
        data_phase <= 1'b0;
        hrdata     <= rdata;
      end
    end
  end

  // Captured transfer attributes, held for the whole data phase
  always_ff @(posedge hclk1) begin
    if (accept) begin
      req_addr  <= haddr;
      req_write <= hwrite;
    end
  end

  assign hready   = addr_phase;
  assign xfer_req = data_phase;

endmodule

// File: rtl/apb_addr_decoder.sv
//--------------------------------------------------------------------------
// APB slave select decode by inclusive start/end address windows
//--------------------------------------------------------------------------

`timescale 1ns/100ps

`include "bridge_params.svh"

module apb_addr_decoder (
  input  ahb_pkg::haddr_t     req_addr,
  output apb_pkg::slave_vec_t slave_sel
);

  import ahb_pkg::*;

  // Window bounds per slave, index matches the psel bit
  localparam haddr_t SLAVE_START [`BRIDGE_NUM_SLAVES] = '{
    `BRIDGE_SLAVE0_START,
    `BRIDGE_SLAVE1_START,
    `BRIDGE_SLAVE2_START,
    `BRIDGE_SLAVE3_START
  };

  localparam haddr_t SLAVE_END [`BRIDGE_NUM_SLAVES] = '{
    `BRIDGE_SLAVE0_END,
    `BRIDGE_SLAVE1_END,
    `BRIDGE_SLAVE2_END,
    `BRIDGE_SLAVE3_END
  };

  // Windows do not overlap, so at most one bit is set
  always_comb begin
    slave_sel = '0;
    for (int i = 0; i < `BRIDGE_NUM_SLAVES; i++) begin
      slave_sel[i] = (req_addr >= SLAVE_START[i]) && (req_addr <= SLAVE_END[i]);
    end
  end

endmodule

// File: rtl/apb_master_fsm.sv
//--------------------------------------------------------------------------
// APB master FSM, IDLE -> SETUP -> ACCESS per AHB transfer
// Drives the shared APB signals and muxes pready/prdata back
//--------------------------------------------------------------------------

`timescale 1ns/100ps

`include "bridge_params.svh"

module apb_master_fsm (
  input  logic                 hclk1,
  input  logic                 hreset_n1,
  input  logic                 xfer_req,
  input  ahb_pkg::haddr_t      req_addr,
  input  logic                 req_write,
  input  apb_pkg::slave_vec_t  slave_sel,
  input  apb_pkg::slave_vec_t  pready,
  input  apb_pkg::prdata_arr_t prdata,
  output ahb_pkg::haddr_t      paddr,
  output logic                 pwrite,
  output apb_pkg::slave_vec_t  psel,
  output logic                 penable,
  output logic                 xfer_done,
  output ahb_pkg::hdata_t      rdata
);

  import apb_pkg::*;

  apb_state_t state;
  logic       pready_sel;
  logic       no_slave;

  //------------------------------------------------------------------------
  // Return path muxing by the registered select
  //------------------------------------------------------------------------
  assign pready_sel = |(psel & pready);
  assign no_slave   = ~|psel;

  // Unselected slaves contribute zero, so unmapped reads return zero
  always_comb begin
    rdata = '0;
    for (int i = 0; i < `BRIDGE_NUM_SLAVES; i++) begin
      if (psel[i]) begin
        rdata = rdata | prdata[i];
      end
    end
  end

  // Unmapped access ends on the first ACCESS edge
  assign xfer_done = (state == APB_ACCESS) && (pready_sel || no_slave);

  //------------------------------------------------------------------------
  // State machine and APB outputs
  //------------------------------------------------------------------------
  always_ff @(posedge hclk1 or negedge hreset_n1) begin
    if (!hreset_n1) begin
      state   <= APB_IDLE;
      psel    <= '0;
      penable <= 1'b0;
      paddr   <= '0;
      pwrite  <= 1'b0;
    end else begin
      case (state)
        APB_IDLE: begin
          if (xfer_req) begin
            state  <= APB_SETUP;
            psel   <= slave_sel;
            paddr  <= req_addr;
            pwrite <= req_write;
          end
        end

        APB_SETUP: begin
          state   <= APB_ACCESS;
          // No penable without a selected slave
          penable <= ~no_slave;
        end

        APB_ACCESS: begin
          // Wait states hold everything stable
          if (xfer_done) begin
            state   <= APB_IDLE;
            psel    <= '0;
            penable <= 1'b0;
          end
        end

        default: begin
          state   <= APB_IDLE;
          psel    <= '0;
          penable <= 1'b0;
        end
      endcase
    end
  end

endmodule

// File: rtl/ahb_apb_bridge.sv
//--------------------------------------------------------------------------
// AHB to APB bridge top for four APB slaves
//--------------------------------------------------------------------------

`timescale 1ns/100ps

module ahb_apb_bridge (
  input  logic                 hclk1,
  input  logic                 hreset_n1,

  // AHB slave port
  input  logic                 hsel,
  input  ahb_pkg::haddr_t      haddr,
  input  ahb_pkg::htrans_t     htrans,
  input  logic                 hwrite,
  input  ahb_pkg::hdata_t      hwdata,
  output logic                 hready,
  output ahb_pkg::hdata_t      hrdata,

  // APB master port
  output ahb_pkg::haddr_t      paddr,
  output logic                 pwrite,
  output apb_pkg::slave_vec_t  psel,
  output logic                 penable,
  output ahb_pkg::hdata_t      pwdata,
  input  apb_pkg::slave_vec_t  pready,
  input  apb_pkg::prdata_arr_t prdata
);

  import ahb_pkg::*;
  import apb_pkg::*;

  logic       xfer_req;
  haddr_t     req_addr;
  logic       req_write;
  logic       xfer_done;
  hdata_t     rdata;
  slave_vec_t slave_sel;

  ahb_slave_if u_ahb_slave_if (
    .hclk1     (hclk1),
    .hreset_n1 (hreset_n1),
    .hsel      (hsel),
    .haddr     (haddr),
    .htrans    (htrans),
    .hwrite    (hwrite),
    .hready    (hready),
    .hrdata    (hrdata),
    .xfer_req  (xfer_req),
    .req_addr  (req_addr),
    .req_write (req_write),
    .xfer_done (xfer_done),
    .rdata     (rdata)
  );

  apb_addr_decoder u_apb_addr_decoder (
    .req_addr  (req_addr),
    .slave_sel (slave_sel)
  );

  apb_master_fsm u_apb_master_fsm (
    .hclk1     (hclk1),
    .hreset_n1 (hreset_n1),
    .xfer_req  (xfer_req),
    .req_addr  (req_addr),
    .req_write (req_write),
    .slave_sel (slave_sel),
    .pready    (pready),
    .prdata    (prdata),
    .paddr     (paddr),
    .pwrite    (pwrite),
    .psel      (psel),
    .penable   (penable),
    .xfer_done (xfer_done),
    .rdata     (rdata)
  );

  // Master holds hwdata through the data phase, which covers the APB access
  assign pwdata = hwdata;

endmodule

// File: tests/ahb_apb_bridge_assert.sv
//--------------------------------------------------------------------------
// APB and AHB protocol assertions, bound into the bridge top
//--------------------------------------------------------------------------

`timescale 1ns/100ps

module ahb_apb_bridge_assert (
  input logic                hclk1,
  input logic                hreset_n1,
  input logic                hready,
  input apb_pkg::slave_vec_t psel,
  input logic                penable,
  input ahb_pkg::haddr_t     paddr,
  input logic                pwrite
);

  // Number of assertion failures so far
  int         fail_cnt = 0;
  logic [3:0] low_cnt;

  // Consecutive cycles with hready low, saturating
  always_ff @(posedge hclk1 or negedge hreset_n1) begin
    if (!hreset_n1) begin
      low_cnt <= '0;
    end else if (hready) begin
      low_cnt <= '0;
    end else if (low_cnt != 4'hF) begin
      low_cnt <= low_cnt + 4'd1;
    end
  end

  penable_needs_psel: assert property (@(posedge hclk1) disable iff (!hreset_n1)
    penable |-> (psel != '0))
    else begin
      $error("penable high with no psel bit set");
      fail_cnt = fail_cnt + 1;
    end

  psel_onehot: assert property (@(posedge hclk1) disable iff (!hreset_n1)
    $onehot0(psel))
    else begin
      $error("more than one psel bit set");
      fail_cnt = fail_cnt + 1;
    end

  // ACCESS keeps the address and direction of SETUP
  access_stable: assert property (@(posedge hclk1) disable iff (!hreset_n1)
    ((psel != '0) && penable) |-> ($stable(paddr) && $stable(pwrite)))
    else begin
      $error("paddr or pwrite changed during the APB access");
      fail_cnt = fail_cnt + 1;
    end

  hready_returns: assert property (@(posedge hclk1) disable iff (!hreset_n1)
    low_cnt <= 4'd8)
    else begin
      $error("hready low for more than 8 cycles");
      fail_cnt = fail_cnt + 1;
    end

endmodule

bind ahb_apb_bridge ahb_apb_bridge_assert u_assert (
  .hclk1     (hclk1),
  .hreset_n1 (hreset_n1),
  .hready    (hready),
  .psel      (psel),
  .penable   (penable),
  .paddr     (paddr),
  .pwrite    (pwrite)
);

// File: tests/ahb_apb_bridge_tb.sv
//--------------------------------------------------------------------------
// Testbench for the AHB to APB bridge
// AHB master stimulus against four APB slave models with wait states
//--------------------------------------------------------------------------

`timescale 1ns/100ps

`include "bridge_params.svh"

module ahb_apb_bridge_tb;

  import ahb_pkg::*;
  import apb_pkg::*;

  localparam int N_SLAVES    = `BRIDGE_NUM_SLAVES;
  localparam int WORDS       = 16;
  localparam int RW_PER_SLV  = 6;
  localparam int DRIVE_DLY   = 10;
  localparam int NUM_XFERS   = 2 * RW_PER_SLV * N_SLAVES + 12;
  localparam int CYCLE_LIMIT = NUM_XFERS * 8 + 8 + 40;

  logic        hclk1 = 1'b0;
  logic        hreset_n1;
  logic        hsel;
  haddr_t      haddr;
  htrans_t     htrans;
  logic        hwrite;
  hdata_t      hwdata;
  logic        hready;
  hdata_t      hrdata;
  haddr_t      paddr;
  logic        pwrite;
  slave_vec_t  psel;
  logic        penable;
  hdata_t      pwdata;
  slave_vec_t  pready;
  prdata_arr_t prdata;

  // Transfer in flight as seen by the slave models
  haddr_t      exp_addr;
  logic        exp_write;
  slave_vec_t  exp_sel;
  int          waits_used;
  logic        setup_seen;

  hdata_t      shadow [N_SLAVES][WORDS];
  hdata_t      slv_mem [N_SLAVES][WORDS];
  logic        exp_is_read_q [$];
  hdata_t      exp_data_q [$];
  logic        hready_prev = 1'b1;
  logic [15:0] lfsr_state = 16'd56;
  int          cycle_cnt = 0;

  ahb_apb_bridge dut (
    .hclk1     (hclk1),
    .hreset_n1 (hreset_n1),
    .hsel      (hsel),
    .haddr     (haddr),
    .htrans    (htrans),
    .hwrite    (hwrite),
    .hwdata    (hwdata),
    .hready    (hready),
    .hrdata    (hrdata),
    .paddr     (paddr),
    .pwrite    (pwrite),
    .psel      (psel),
    .penable   (penable),
    .pwdata    (pwdata),
    .pready    (pready),
    .prdata    (prdata)
  );

  always #50 hclk1 = ~hclk1;

  //------------------------------------------------------------------------
  // Helpers
  //------------------------------------------------------------------------
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    // Taps 16, 14, 13, 11
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[15]};
    end
  endtask

  // Initial memory contents differ for every slave and word
  function automatic hdata_t fill_word(input int s, input int w);
    return 32'hC0DE_0000 + 32'(s) * 32'h0101_0000 + 32'(w) * 32'h0000_0111;
  endfunction

  // Expected hrdata is the shadow word, or zero when unmapped
  function automatic hdata_t ref_read(input haddr_t addr);
    if (addr > `BRIDGE_SLAVE3_END) begin
      return '0;
    end
    return shadow[addr[13:12]][addr[5:2]];
  endfunction

  function automatic slave_vec_t expected_psel(input haddr_t addr);
    if (addr > `BRIDGE_SLAVE3_END) begin
      return '0;
    end
    return slave_vec_t'(1) << addr[13:12];
  endfunction

  task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic check_idle_outputs(input string when);
    compare_value(32'(hready), 32'd1, {"hready ", when});
    compare_value(32'(psel), 32'd0, {"psel ", when});
    compare_value(32'(penable), 32'd0, {"penable ", when});
    compare_value(hrdata, 32'd0, {"hrdata ", when});
  endtask

  // One NONSEQ transfer entered and left just after a rising edge
  task automatic ahb_transfer(input haddr_t addr, input logic write, input hdata_t wdata);
    int lat;
    int exp_lat;

    exp_addr   = addr;
    exp_write  = write;
    exp_sel    = expected_psel(addr);
    setup_seen = 1'b0;
    exp_is_read_q.push_back(!write);
    exp_data_q.push_back(ref_read(addr));
    hsel   = 1'b1;
    haddr  = addr;
    htrans = HTRANS_NONSEQ;
    hwrite = write;
    @(posedge hclk1);
    #(DRIVE_DLY);
    hsel   = 1'b0;
    htrans = HTRANS_IDLE;
    haddr  = '0;
    hwdata = wdata;
    lat    = 0;
    while (!hready) begin
      lat = lat + 1;
      @(posedge hclk1);
      #(DRIVE_DLY);
    end
    // Three cycles for SETUP and ACCESS plus the slave's wait states
    exp_lat = (exp_sel != '0) ? 3 + waits_used : 3;
    compare_value(lat, exp_lat, "cycles with hready low");
    compare_value(32'(setup_seen), 32'(exp_sel != '0), "SETUP cycle seen by a slave");
    if (write && (addr <= `BRIDGE_SLAVE3_END)) begin
      shadow[addr[13:12]][addr[5:2]] = wdata;
    end
  endtask

  task automatic ignored_transfer(input logic sel, input htrans_t trans, input haddr_t addr);
    exp_sel = '0;
    hsel    = sel;
    htrans  = trans;
    haddr   = addr;
    hwrite  = 1'b1;
    repeat (3) begin
      @(posedge hclk1);
      #(DRIVE_DLY);
      compare_value(32'(hready), 32'd1, "hready on an ignored transfer");
      compare_value(32'(psel), 32'd0, "psel on an ignored transfer");
    end
    hsel   = 1'b0;
    htrans = HTRANS_IDLE;
  endtask

  //------------------------------------------------------------------------
  // APB slave models
  //------------------------------------------------------------------------
  initial begin : apb_slave_models
    logic [31:0] rnd;
    int          wait_cnt [N_SLAVES];

    for (int s = 0; s < N_SLAVES; s++) begin
      wait_cnt[s] = 0;
      for (int w = 0; w < WORDS; w++) begin
        slv_mem[s][w] = fill_word(s, w);
      end
    end
    pready = '0;
    prdata = '0;
    forever begin
      @(posedge hclk1);
      #(DRIVE_DLY);
      if (psel != '0) begin
        compare_value(32'(psel), 32'(exp_sel), "psel for the transfer in flight");
      end
      for (int i = 0; i < N_SLAVES; i++) begin
        if (!psel[i]) begin
          pready[i] = 1'b0;
        end else if (!penable) begin
          // SETUP cycle
          compare_value(paddr, exp_addr, "paddr in SETUP");
          compare_value(32'(pwrite), 32'(exp_write), "pwrite in SETUP");
          setup_seen = 1'b1;
          take_bits(2, rnd);
          wait_cnt[i] = int'(rnd[1:0]);
          waits_used  = wait_cnt[i];
          pready[i]   = 1'b0;
        end else if (wait_cnt[i] > 0) begin
          wait_cnt[i] = wait_cnt[i] - 1;
          pready[i]   = 1'b0;
        end else if (!pready[i]) begin
          // Access completes on the next edge
          pready[i] = 1'b1;
          if (pwrite) begin
            compare_value(pwdata, hwdata, "pwdata on write");
            slv_mem[i][paddr[5:2]] = pwdata;
          end else begin
            prdata[i] = slv_mem[i][paddr[5:2]];
          end
        end
      end
    end
  end

  //------------------------------------------------------------------------
  // Completion checker for hready rising at the end of a transfer
  //------------------------------------------------------------------------
  always @(negedge hclk1) begin : completion_checker
    logic   rise;
    logic   is_read;
    hdata_t expected;

    rise        = hreset_n1 && hready && !hready_prev;
    hready_prev = hready;
    if (rise && (exp_data_q.size() == 0)) begin
      $display("Transfer completed at %0t with no transfer in flight", $time);
      $display("test failed");
      $fatal(1);
    end else if (rise) begin
      is_read  = exp_is_read_q.pop_front();
      expected = exp_data_q.pop_front();
      if (is_read) begin
        compare_value(hrdata, expected, "hrdata of read");
      end
    end
  end

  always @(posedge hclk1) begin : watchdog
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout, simulation still running after %0d cycles", CYCLE_LIMIT);
      $display("test failed");
      $fatal(1);
    end
  end

  //------------------------------------------------------------------------
  // Stimulus
  //------------------------------------------------------------------------
  initial begin : stimulus
    logic [31:0] rnd;
    haddr_t      a;
    hdata_t      d;
    haddr_t      written [$];

    hreset_n1  = 1'b0;
    hsel       = 1'b0;
    haddr      = '0;
    htrans     = HTRANS_IDLE;
    hwrite     = 1'b0;
    hwdata     = '0;
    exp_addr   = '0;
    exp_write  = 1'b0;
    exp_sel    = '0;
    setup_seen = 1'b0;
    for (int s = 0; s < N_SLAVES; s++) begin
      for (int w = 0; w < WORDS; w++) begin
        shadow[s][w] = fill_word(s, w);
      end
    end

    repeat (8) @(posedge hclk1);
    #(DRIVE_DLY);
    check_idle_outputs("in reset");
    hreset_n1 = 1'b1;
    @(posedge hclk1);
    #(DRIVE_DLY);
    check_idle_outputs("after reset");

    // Random words in every window written and then read back
    for (int s = 0; s < N_SLAVES; s++) begin
      for (int k = 0; k < RW_PER_SLV; k++) begin
        take_bits(10, rnd);
        a = (haddr_t'(s) << 12) | {20'h0, rnd[9:0], 2'b00};
        take_bits(32, d);
        ahb_transfer(a, 1'b1, d);
        written.push_back(a);
      end
    end
    foreach (written[i]) begin
      take_bits(32, d);
      ahb_transfer(written[i], 1'b0, d);
    end

    // Unmapped space and then the words its low bits alias
    take_bits(32, d);
    ahb_transfer(32'h0000_4000, 1'b1, d);
    ahb_transfer(32'h8000_1004, 1'b1, ~d);
    ahb_transfer(32'h0000_4000, 1'b0, d);
    ahb_transfer(32'h8000_1004, 1'b0, d);
    ahb_transfer(32'h0000_0000, 1'b0, d);
    ahb_transfer(32'h0000_1004, 1'b0, d);
    ahb_transfer(written[0], 1'b0, d);
    ahb_transfer(written[written.size()-1], 1'b0, d);

    ignored_transfer(1'b1, HTRANS_IDLE, 32'h0000_1004);
    ignored_transfer(1'b1, HTRANS_BUSY, 32'h0000_2008);
    ignored_transfer(1'b0, HTRANS_NONSEQ, 32'h0000_3010);

    repeat (2) @(negedge hclk1);
    if (dut.u_assert.fail_cnt != 0) begin
      $display("Protocol assertions failed %0d times", dut.u_assert.fail_cnt);
      $display("test failed");
      $fatal(1);
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

// File: verilog.f
+incdir+rtl
rtl/ahb_pkg.sv
rtl/apb_pkg.sv
rtl/ahb_slave_if.sv
rtl/apb_addr_decoder.sv
rtl/apb_master_fsm.sv
rtl/ahb_apb_bridge.sv
tests/ahb_apb_bridge_assert.sv
tests/ahb_apb_bridge_tb.sv

// File: Makefile
# Verilator build and run of the AHB to APB bridge testbench

VERILATOR ?= verilator
TOP       ?= ahb_apb_bridge_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(BUILD_DIR)
